// File: Makefile
# Verilator build and run for the peripheral subsystem

VERILATOR ?= verilator
TOP       ?= tb_soc_periph
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^test passed$$"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: gpio_regs.sv
// GPIO register block
// output value, output-enable-bar and interrupt mask registers,
// a 2-flop input synchronizer and a level interrupt

`timescale 1ns/100ps

`include "soc_cfg.svh"

module gpio_regs import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  mem_req_t req_i,
  output mem_rsp_t rsp_o,
  input  gpio_t    gpio_in_i,
  output gpio_t    gpio_out_o,
  output gpio_t    gpio_oeb_o,
  output logic     irq_o
);

  logic       accept_q;
  logic       ready_q;
  data_t      rdata_q;
  data_t      rd_mux;
  logic       wr_en;
  logic [3:0] reg_off;
  gpio_t      out_q;
  gpio_t      oeb_q;
  gpio_t      mask_q;
  gpio_t      sync1_q;
  gpio_t      sync2_q;

  assign reg_off = {req_i.addr[3:2], 2'b00};
  // writes land on the edge where ready rises
  assign wr_en   = accept_q & req_i.valid & (|req_i.wstrb);

  // handshake, one idle cycle then a ready pulse
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      accept_q <= 1'b0;
      ready_q  <= 1'b0;
    end else begin
      accept_q <= req_i.valid & ~accept_q & ~ready_q;
      ready_q  <= accept_q & req_i.valid;
    end
  end

  always_comb begin
    case (reg_off)
      `REG_OFF_0: rd_mux = data_t'(out_q);
      `REG_OFF_1: rd_mux = data_t'(oeb_q);
      `REG_OFF_2: rd_mux = data_t'(sync2_q);
      default:    rd_mux = data_t'(mask_q);
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (accept_q) begin
      rdata_q <= rd_mux;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_q   <= '0;
      oeb_q   <= '1;
      mask_q  <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= gpio_in_i;
      sync2_q <= sync1_q;
      // only byte 0 carries register bits
      if (wr_en && req_i.wstrb[0]) begin
        case (reg_off)
          `REG_OFF_0: out_q  <= req_i.wdata[`GPIO_W-1:0];
          `REG_OFF_1: oeb_q  <= req_i.wdata[`GPIO_W-1:0];
          `REG_OFF_3: mask_q <= req_i.wdata[`GPIO_W-1:0];
          default: ;
        endcase
      end
    end
  end

  assign rsp_o.ready = ready_q;
  assign rsp_o.rdata = ready_q ? rdata_q : '0;

  assign gpio_out_o = out_q;
  assign gpio_oeb_o = oeb_q;
  assign irq_o      = |(sync2_q & mask_q);

endmodule

// File: periph_bus.sv
// Peripheral bus
// decodes the core address into the gpio or timer page, routes
// valid to the selected slave and ORs the slave responses back;
// unmapped accesses are answered here with rdata zero

`timescale 1ns/100ps

`include "soc_cfg.svh"

module periph_bus import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  mem_req_t core_req_i,
  output mem_rsp_t core_rsp_o,
  output mem_req_t gpio_req_o,
  input  mem_rsp_t gpio_rsp_i,
  output mem_req_t timer_req_o,
  input  mem_rsp_t timer_rsp_i
);

  localparam addr_t gpio_base  = `GPIO_BASE;
  localparam addr_t timer_base = `TIMER_BASE;

  logic sel_gpio;
  logic sel_timer;
  logic unm_valid;
  logic unm_accept_q;
  logic unm_ready_q;

  // page match on the bits above the block page
  assign sel_gpio  = core_req_i.addr[31:`PERIPH_PAGE_BITS] ==
                     gpio_base[31:`PERIPH_PAGE_BITS];
  assign sel_timer = core_req_i.addr[31:`PERIPH_PAGE_BITS] ==
                     timer_base[31:`PERIPH_PAGE_BITS];
  assign unm_valid = core_req_i.valid & ~sel_gpio & ~sel_timer;

  // payload goes to both, valid only to the selected one
  always_comb begin
    gpio_req_o        = core_req_i;
    gpio_req_o.valid  = core_req_i.valid & sel_gpio;
    timer_req_o       = core_req_i;
    timer_req_o.valid = core_req_i.valid & sel_timer;
  end

  // unmapped responder, writes are dropped
  // ready_q also acts as the answered bit for the held valid
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      unm_accept_q <= 1'b0;
      unm_ready_q  <= 1'b0;
    end else begin
      unm_accept_q <= unm_valid & ~unm_accept_q & ~unm_ready_q;
      unm_ready_q  <= unm_accept_q & unm_valid;
    end
  end

  // only one slave is ever active, so an OR is enough
  // an idle slave drives rdata zero
  always_comb begin
    core_rsp_o.ready = gpio_rsp_i.ready | timer_rsp_i.ready | unm_ready_q;
    core_rsp_o.rdata = gpio_rsp_i.rdata | timer_rsp_i.rdata;
  end

endmodule

// File: project.f
+incdir+.
soc_pkg.sv
periph_bus.sv
gpio_regs.sv
timer_regs.sv
soc_periph_top.sv
soc_periph_chk.sv
tb_soc_periph.sv

// File: soc_cfg.svh
// Peripheral SoC configuration
// address map, register offsets and widths shared by the
// bus, the register blocks and the testbench

`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// one word per block base
`define GPIO_BASE 32'h0300_0000
`define TIMER_BASE 32'h0300_1000

// low address bits inside one block page
`define PERIPH_PAGE_BITS 12

// register word offsets, decoded from addr[3:2]
`define REG_OFF_0 4'h0
`define REG_OFF_1 4'h4
`define REG_OFF_2 4'h8
`define REG_OFF_3 4'hC

`define DATA_W 32
`define GPIO_W 8

`endif

// File: soc_periph_chk.sv
// Peripheral bus checker
// concurrent assertions on the native handshake and the
// reset state, bound into every periph_bus instance

`timescale 1ns/100ps

module soc_periph_chk import soc_pkg::*; (
  input logic     clk_i,
  input logic     arst_n_i,
  input mem_req_t core_req_i,
  input mem_rsp_t core_rsp_o,
  input mem_req_t gpio_req_o,
  input mem_rsp_t gpio_rsp_i,
  input mem_req_t timer_req_o,
  input mem_rsp_t timer_rsp_i
);

  // ready is a single-cycle pulse
  ready_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    core_rsp_o.ready |=> !core_rsp_o.ready)
    else $error("core ready high in two consecutive cycles");

  // ready answers a valid seen in the cycle before
  ready_after_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    core_rsp_o.ready |-> $past(core_req_i.valid))
    else $error("core ready without a preceding valid");

  gpio_ready_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    gpio_rsp_i.ready |-> gpio_req_o.valid)
    else $error("gpio ready without gpio valid");

  timer_ready_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    timer_rsp_i.ready |-> timer_req_o.valid)
    else $error("timer ready without timer valid");

  ready_low_in_reset: assert property (@(posedge clk_i)
    !arst_n_i |-> !core_rsp_o.ready)
    else $error("core ready high during reset");

endmodule

bind periph_bus soc_periph_chk u_chk (.*);

// File: soc_periph_top.sv
// Peripheral subsystem top
// the core-facing native port enters the peripheral bus, which
// serves the gpio and timer blocks; their interrupt lines are
// packed into a small vector for the core

`timescale 1ns/100ps

module soc_periph_top import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  mem_req_t core_req_i,
  output mem_rsp_t core_rsp_o,
  input  gpio_t    gpio_in_i,
  output gpio_t    gpio_out_o,
  output gpio_t    gpio_oeb_o,
  output irq_vec_t irq_o
);

  // gpio if
  mem_req_t s_gpio_req;
  mem_rsp_t s_gpio_rsp;
  // timer if
  mem_req_t s_timer_req;
  mem_rsp_t s_timer_rsp;
  // irq
  logic     s_gpio_irq;
  logic     s_timer_irq;

  assign irq_o = {s_timer_irq, s_gpio_irq};

  periph_bus u_periph_bus (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .core_req_i  (core_req_i),
    .core_rsp_o  (core_rsp_o),
    .gpio_req_o  (s_gpio_req),
    .gpio_rsp_i  (s_gpio_rsp),
    .timer_req_o (s_timer_req),
    .timer_rsp_i (s_timer_rsp)
  );

  gpio_regs u_gpio_regs (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .req_i      (s_gpio_req),
    .rsp_o      (s_gpio_rsp),
    .gpio_in_i  (gpio_in_i),
    .gpio_out_o (gpio_out_o),
    .gpio_oeb_o (gpio_oeb_o),
    .irq_o      (s_gpio_irq)
  );

  timer_regs u_timer_regs (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (s_timer_req),
    .rsp_o    (s_timer_rsp),
    .irq_o    (s_timer_irq)
  );

endmodule

// File: soc_pkg.sv
// Peripheral SoC types
// vector typedefs and the native memory port request and
// response structs used between the core, the bus and the slaves

`include "soc_cfg.svh"

package soc_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [`DATA_W-1:0] data_t;
  // all zero means a read
  typedef logic [3:0] wstrb_t;
  typedef logic [`GPIO_W-1:0] gpio_t;

  // bit 0 gpio, bit 1 timer
  typedef logic [1:0] irq_vec_t;

  // valid and payload are held until ready
  typedef struct packed {
    logic   valid;
    addr_t  addr;
    data_t  wdata;
    wstrb_t wstrb;
  } mem_req_t;

  // ready is a single-cycle pulse, rdata is valid with it
  typedef struct packed {
    logic  ready;
    data_t rdata;
  } mem_rsp_t;

endpackage

// File: tb_soc_periph.sv
// Peripheral subsystem testbench
// plays the core on the native port with LFSR stimulus and
// checks every response against a register model

`timescale 1ns/100ps

`include "soc_cfg.svh"

module tb_soc_periph import soc_pkg::*; ();

  localparam int num_txn    = 200;
  localparam int margin_cyc = 500;

  logic     clk;
  logic     arst_n;
  mem_req_t core_req;
  mem_rsp_t core_rsp;
  gpio_t    gpio_in;
  gpio_t    gpio_out;
  gpio_t    gpio_oeb;
  irq_vec_t irq;

  logic [31:0] lfsr_q = 32'h5f14;
  int          txn_cnt = 0;

  // register model
  gpio_t m_out;
  gpio_t m_oeb;
  gpio_t m_mask;
  gpio_t m_in;
  data_t m_cmp;
  logic  m_en;

  soc_periph_top DUT (
    .clk_i      (clk),
    .arst_n_i   (arst_n),
    .core_req_i (core_req),
    .core_rsp_o (core_rsp),
    .gpio_in_i  (gpio_in),
    .gpio_out_o (gpio_out),
    .gpio_oeb_o (gpio_oeb),
    .irq_o      (irq)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #((num_txn * 10 + margin_cyc) * 4);
    $display("watchdog expired before the tests finished");
    $display("test failed");
    $fatal(1);
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t wd, input wstrb_t s);
    data_t r;
    r = old;
    for (int i = 0; i < 4; i++) begin
      if (s[i]) r[8*i +: 8] = wd[8*i +: 8];
    end
    return r;
  endfunction

  task automatic check_eq(input string name, input data_t exp, input data_t act);
    assert (act === exp) else begin
      $display("** Error: %s expected 0x%0h actual 0x%0h", name, exp, act);
      $display("test failed");
      $fatal(1);
    end
  endtask

  // one native access, ready must come on the second edge
  task automatic bus_access(input addr_t addr, input data_t wdata, input wstrb_t wstrb,
                            output data_t rdata);
    int edges;
    @(posedge clk);
    #1;
    core_req.valid = 1'b1;
    core_req.addr  = addr;
    core_req.wdata = wdata;
    core_req.wstrb = wstrb;
    edges = 0;
    do begin
      @(posedge clk);
      #1;
      edges++;
    end while (!core_rsp.ready && edges < 3);
    assert (core_rsp.ready && edges == 2) else begin
      $display("ready did not arrive on the second edge after valid (addr 0x%0h)", addr);
      $display("test failed");
      $fatal(1);
    end
    rdata = core_rsp.rdata;
    // request stays up through the ready cycle, dropped after its edge
    @(posedge clk);
    #1;
    core_req.valid = 1'b0;
    txn_cnt++;
  endtask

  task automatic write_reg(input addr_t addr, input data_t wdata, input wstrb_t wstrb);
    data_t dummy;
    bus_access(addr, wdata, wstrb, dummy);
  endtask

  task automatic read_check(input string name, input addr_t addr, input data_t exp);
    data_t rd;
    bus_access(addr, '0, 4'h0, rd);
    check_eq(name, exp, rd);
  endtask

  task automatic check_all_regs();
    read_check("gpio_out_reg", `GPIO_BASE + `REG_OFF_0, data_t'(m_out));
    read_check("gpio_oeb_reg", `GPIO_BASE + `REG_OFF_1, data_t'(m_oeb));
    read_check("gpio_in_reg", `GPIO_BASE + `REG_OFF_2, data_t'(m_in));
    read_check("gpio_mask_reg", `GPIO_BASE + `REG_OFF_3, data_t'(m_mask));
    read_check("timer_ctrl", `TIMER_BASE + `REG_OFF_0, {31'd0, m_en});
    read_check("timer_cmp", `TIMER_BASE + `REG_OFF_1, m_cmp);
    check_eq("gpio_out_o", data_t'(m_out), data_t'(gpio_out));
    check_eq("gpio_oeb_o", data_t'(m_oeb), data_t'(gpio_oeb));
  endtask

  initial begin
    data_t  wd;
    data_t  rd;
    wstrb_t ws;
    addr_t  ua;
    logic [1:0] idx;
    core_req = '0;
    gpio_in  = '0;
    arst_n   = 1'b0;
    m_out = '0;
    m_oeb = '1;
    m_mask = '0;
    m_in = '0;
    m_cmp = '0;
    m_en = 1'b0;
    repeat (4) @(posedge clk);
    #1 arst_n = 1'b1;

    // reset values
    check_eq("irq_o", '0, data_t'(irq));
    check_all_regs();
    read_check("timer_cnt", `TIMER_BASE + `REG_OFF_2, '0);
    read_check("timer_status", `TIMER_BASE + `REG_OFF_3, '0);

    // random gpio writes, only byte 0 counts
    for (int i = 0; i < 16; i++) begin
      idx = rand_bits(2);
      wd  = rand_bits(32);
      ws  = rand_bits(4);
      write_reg(`GPIO_BASE + {28'd0, idx, 2'b00}, wd, ws);
      if (ws[0] && idx == 2'd0) m_out = wd[7:0];
      if (ws[0] && idx == 2'd1) m_oeb = wd[7:0];
      if (ws[0] && idx == 2'd3) m_mask = wd[7:0];
      check_eq("gpio_out_o", data_t'(m_out), data_t'(gpio_out));
      check_eq("gpio_oeb_o", data_t'(m_oeb), data_t'(gpio_oeb));
      read_check("gpio_out_reg", `GPIO_BASE + `REG_OFF_0, data_t'(m_out));
      read_check("gpio_oeb_reg", `GPIO_BASE + `REG_OFF_1, data_t'(m_oeb));
      read_check("gpio_mask_reg", `GPIO_BASE + `REG_OFF_3, data_t'(m_mask));
    end

    // input synchronizer and gpio interrupt
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      #1;
      m_in    = rand_bits(8);
      gpio_in = m_in;
      repeat (3) @(posedge clk);
      #1;
      check_eq("irq_o[0]", data_t'(|(m_in & m_mask)), data_t'(irq[0]));
      read_check("gpio_in_reg", `GPIO_BASE + `REG_OFF_2, data_t'(m_in));
    end

    // compare merge, then a small compare with the timer running
    wd = rand_bits(32);
    ws = rand_bits(4);
    write_reg(`TIMER_BASE + `REG_OFF_1, wd, ws);
    m_cmp = merge_bytes(m_cmp, wd, ws);
    read_check("timer_cmp", `TIMER_BASE + `REG_OFF_1, m_cmp);
    m_cmp = 32'd4 + rand_bits(4);
    write_reg(`TIMER_BASE + `REG_OFF_1, m_cmp, 4'hf);
    write_reg(`TIMER_BASE + `REG_OFF_0, 32'd1, 4'h1);
    m_en = 1'b1;
    read_check("timer_ctrl", `TIMER_BASE + `REG_OFF_0, 32'd1);
    for (int i = 0; i < 6; i++) begin
      bus_access(`TIMER_BASE + `REG_OFF_2, '0, 4'h0, rd);
      assert (rd <= m_cmp) else begin
        $display("** Error: timer_cnt 0x%0h above compare 0x%0h", rd, m_cmp);
        $display("test failed");
        $fatal(1);
      end
    end
    repeat (m_cmp + 3) @(posedge clk);
    #1;
    check_eq("irq_o[1]", 32'd1, data_t'(irq[1]));
    read_check("timer_status", `TIMER_BASE + `REG_OFF_3, 32'd1);
    write_reg(`TIMER_BASE + `REG_OFF_0, 32'd0, 4'h1);
    m_en = 1'b0;
    write_reg(`TIMER_BASE + `REG_OFF_3, 32'd1, 4'h1);
    check_eq("irq_o[1]", 32'd0, data_t'(irq[1]));
    read_check("timer_status", `TIMER_BASE + `REG_OFF_3, 32'd0);

    // unmapped accesses return zero and touch nothing
    for (int i = 0; i < 8; i++) begin
      do begin
        ua = rand_bits(32);
      end while (ua[31:12] == 20'h03000 || ua[31:12] == 20'h03001);
      bus_access(ua, rand_bits(32), rand_bits(4), rd);
      check_eq("unmapped_rdata", '0, rd);
      read_check("unmapped_rdata", ua, '0);
    end
    check_all_regs();

    $display("%0d transactions done", txn_cnt);
    $display("test passed");
    $finish;
  end

endmodule

// File: timer_regs.sv
// Timer register block
// free-running counter with enable, wraps to zero on compare
// match and sets a sticky flag that drives the interrupt

`timescale 1ns/100ps

`include "soc_cfg.svh"

module timer_regs import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  mem_req_t req_i,
  output mem_rsp_t rsp_o,
  output logic     irq_o
);

  logic       accept_q;
  logic       ready_q;
  data_t      rdata_q;
  data_t      rd_mux;
  logic       wr_en;
  logic [3:0] reg_off;
  logic       en_q;
  data_t      cmp_q;
  data_t      cnt_q;
  logic       flag_q;
  logic       match;
  logic       flag_clr;

  assign reg_off  = {req_i.addr[3:2], 2'b00};
  assign wr_en    = accept_q & req_i.valid & (|req_i.wstrb);
  assign match    = en_q & (cnt_q == cmp_q);
  // write 1 to clear
  assign flag_clr = wr_en & (reg_off == `REG_OFF_3) & req_i.wstrb[0] & req_i.wdata[0];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      accept_q <= 1'b0;
      ready_q  <= 1'b0;
    end else begin
      accept_q <= req_i.valid & ~accept_q & ~ready_q;
      ready_q  <= accept_q & req_i.valid;
    end
  end

  always_comb begin
    case (reg_off)
      `REG_OFF_0: rd_mux = {31'd0, en_q};
      `REG_OFF_1: rd_mux = cmp_q;
      `REG_OFF_2: rd_mux = cnt_q;
      default:    rd_mux = {31'd0, flag_q};
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (accept_q) begin
      rdata_q <= rd_mux;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_q   <= 1'b0;
      cmp_q  <= '0;
      cnt_q  <= '0;
      flag_q <= 1'b0;
    end else begin
      if (wr_en && reg_off == `REG_OFF_0 && req_i.wstrb[0]) begin
        en_q <= req_i.wdata[0];
      end
      if (wr_en && reg_off == `REG_OFF_1) begin
        for (int i = 0; i < 4; i++) begin
          if (req_i.wstrb[i]) cmp_q[8*i +: 8] <= req_i.wdata[8*i +: 8];
        end
      end
      // wrap to zero instead of counting past compare
      if (match) begin
        cnt_q <= '0;
      end else if (en_q) begin
        cnt_q <= cnt_q + 1'b1;
      end
      // a new match wins over a clear in the same cycle
      flag_q <= (flag_q & ~flag_clr) | match;
    end
  end

  assign rsp_o.ready = ready_q;
  assign rsp_o.rdata = ready_q ? rdata_q : '0;
  assign irq_o       = flag_q;

endmodule
